// File: soc_settings.svh
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// ------------------------------------------------------------------------
// Address map
// ------------------------------------------------------------------------

// progMem region, selected by bit 20 with nothing set above it
`define PROG_BASE 32'h0010_0000

// GPIO output register
`define GPIO_ADDR 32'h0300_0000

// ------------------------------------------------------------------------
// Sizes
// ------------------------------------------------------------------------

// In 32-bit words
`define PROG_WORDS_LOG2 13
`define RAM_WORDS_LOG2 10

// Output pins driven by the GPIO register
`define GPIO_WIDTH 8

`endif

// File: socPkg.sv
`include "soc_settings.svh"
`default_nettype none

package socPkg;

    // ------------------------------------------------------------------------
    // Native memory bus
    // ------------------------------------------------------------------------

    // Master to target, wstrb of zero is a read
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } busReq;

    // Target to master
    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
    } busRsp;

    // ------------------------------------------------------------------------
    // Firmware rewrite port
    // ------------------------------------------------------------------------

    // One word per strobe, index counts words
    typedef struct packed {
        logic                        wen;
        logic [`PROG_WORDS_LOG2-1:0] index;
        logic [31:0]                 data;
    } fwWrite;

endpackage

`default_nettype wire

// File: progMem.sv
`include "soc_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module progMem (
    input  wire                clk,
    input  wire                rstn,
    input  wire socPkg::busReq req,
    output socPkg::busRsp      rsp,
    input  wire socPkg::fwWrite fw
);

    localparam int WORDS = 1 << `PROG_WORDS_LOG2;

    logic [31:0]                 mem [0:WORDS-1];
    logic [31:0]                 memData;
    logic [`PROG_WORDS_LOG2-1:0] wordIdx;
    logic                        readyQ;
    logic                        isReadQ;

    // Word address bits of the byte address
    assign wordIdx = req.addr[`PROG_WORDS_LOG2+1:2];

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------

    // Bus side is read only, a same-edge firmware write is seen one cycle later
    always_ff @(posedge clk) begin
        if (req.valid) begin
            memData <= mem[wordIdx];
        end
    end

    always_ff @(posedge clk) begin
        if (fw.wen) begin
            mem[fw.index] <= fw.data;
        end
    end

    // ------------------------------------------------------------------------
    // Acknowledge
    // ------------------------------------------------------------------------

    // Never acknowledges in the cycle right after its own ready
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            readyQ  <= 1'b0;
            isReadQ <= 1'b0;
        end else begin
            readyQ  <= req.valid && !readyQ;
            isReadQ <= req.wstrb == 4'b0000;
        end
    end

    // Data stays zero outside a read acknowledge so the decoder can OR it
    assign rsp.ready = readyQ;
    assign rsp.rdata = (readyQ && isReadQ) ? memData : 32'h0;

endmodule

`default_nettype wire

// File: dataRam.sv
`include "soc_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module dataRam (
    input  wire                clk,
    input  wire                rstn,
    input  wire socPkg::busReq req,
    output socPkg::busRsp      rsp
);

    localparam int WORDS = 1 << `RAM_WORDS_LOG2;

    logic [31:0]                mem [0:WORDS-1];
    logic [31:0]                ramData;
    logic [`RAM_WORDS_LOG2-1:0] wordIdx;
    logic                       accept;
    logic                       isRead;
    logic                       readyQ;
    logic                       isReadQ;

    assign wordIdx = req.addr[`RAM_WORDS_LOG2+1:2];
    assign isRead  = req.wstrb == 4'b0000;

    // A request is taken on its first valid cycle only
    assign accept = req.valid && !readyQ;

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------

    // Byte lanes without a strobe keep their old value
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int b = 0; b < 4; b++) begin
                if (req.wstrb[b]) begin
                    mem[wordIdx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
            ramData <= mem[wordIdx];
        end
    end

    // ------------------------------------------------------------------------
    // Acknowledge
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            readyQ  <= 1'b0;
            isReadQ <= 1'b0;
        end else begin
            readyQ  <= accept;
            isReadQ <= isRead;
        end
    end

    // Zero on writes and while idle
    assign rsp.ready = readyQ;
    assign rsp.rdata = (readyQ && isReadQ) ? ramData : 32'h0;

endmodule

`default_nettype wire

// File: gpioPort.sv
`include "soc_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module gpioPort (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire socPkg::busReq     req,
    output socPkg::busRsp          rsp,
    output logic [`GPIO_WIDTH-1:0] gpioOut
);

    logic [`GPIO_WIDTH-1:0] gpioQ;
    logic                   accept;
    logic                   readyQ;
    logic                   isReadQ;

    assign accept = req.valid && !readyQ;

    // ------------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------------

    // Only byte lane 0 carries the pin value
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            gpioQ <= '0;
        end else if (accept && req.wstrb[0]) begin
            gpioQ <= req.wdata[`GPIO_WIDTH-1:0];
        end
    end

    assign gpioOut = gpioQ;

    // ------------------------------------------------------------------------
    // Acknowledge and readback
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            readyQ  <= 1'b0;
            isReadQ <= 1'b0;
        end else begin
            readyQ  <= accept;
            isReadQ <= req.wstrb == 4'b0000;
        end
    end

    assign rsp.ready = readyQ;
    assign rsp.rdata = (readyQ && isReadQ) ? {{(32 - `GPIO_WIDTH){1'b0}}, gpioQ} : 32'h0;

endmodule

`default_nettype wire

// File: busDecode.sv
`include "soc_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module busDecode (
    input  wire                clk,
    input  wire                rstn,
    input  wire socPkg::busReq req,
    output socPkg::busRsp      rsp,
    output socPkg::busReq      progReq,
    output socPkg::busReq      ramReq,
    output socPkg::busReq      gpioReq,
    input  wire socPkg::busRsp progRsp,
    input  wire socPkg::busRsp ramRsp,
    input  wire socPkg::busRsp gpioRsp,
    output logic               busError
);

    localparam logic [31:0] PROG_BASE = `PROG_BASE;
    localparam logic [31:0] PROG_MASK = ~(PROG_BASE - 32'h1);
    localparam logic [31:0] GPIO_ADDR = `GPIO_ADDR;
    localparam logic [31:0] RAM_BYTES = 32'h1 << (`RAM_WORDS_LOG2 + 2);

    logic gpioHit;
    logic progHit;
    logic ramHit;
    logic unmapped;
    logic errReadyQ;
    logic busErrorQ;

    // ------------------------------------------------------------------------
    // Address map, first match wins
    // ------------------------------------------------------------------------

    assign gpioHit  = req.addr[31:2] == GPIO_ADDR[31:2];
    assign progHit  = !gpioHit && ((req.addr & PROG_MASK) == PROG_BASE);
    assign ramHit   = !gpioHit && !progHit && (req.addr < RAM_BYTES);
    assign unmapped = !gpioHit && !progHit && !ramHit;

    // Address and data fan out, valid goes to one target only
    always_comb begin
        progReq       = req;
        ramReq        = req;
        gpioReq       = req;
        progReq.valid = req.valid && progHit;
        ramReq.valid  = req.valid && ramHit;
        gpioReq.valid = req.valid && gpioHit;
    end

    // ------------------------------------------------------------------------
    // Unmapped access
    // ------------------------------------------------------------------------

    // Same one-cycle acknowledge as a target, error flag is sticky
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            errReadyQ <= 1'b0;
            busErrorQ <= 1'b0;
        end else begin
            errReadyQ <= req.valid && unmapped && !errReadyQ;
            if (req.valid && unmapped) begin
                busErrorQ <= 1'b1;
            end
        end
    end

    assign busError = busErrorQ;

    // At most one target answers, idle targets return zero data
    assign rsp.ready = progRsp.ready | ramRsp.ready | gpioRsp.ready | errReadyQ;
    assign rsp.rdata = progRsp.rdata | ramRsp.rdata | gpioRsp.rdata;

endmodule

`default_nettype wire

// File: socTop.sv
`include "soc_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module socTop (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire socPkg::busReq     req,
    output socPkg::busRsp          rsp,
    input  wire socPkg::fwWrite    fw,
    output logic [`GPIO_WIDTH-1:0] gpioOut,
    output logic                   busError
);

    socPkg::busReq progReq;
    socPkg::busReq ramReq;
    socPkg::busReq gpioReq;
    socPkg::busRsp progRsp;
    socPkg::busRsp ramRsp;
    socPkg::busRsp gpioRsp;

    busDecode decode (
        .clk      (clk),
        .rstn     (rstn),
        .req      (req),
        .rsp      (rsp),
        .progReq  (progReq),
        .ramReq   (ramReq),
        .gpioReq  (gpioReq),
        .progRsp  (progRsp),
        .ramRsp   (ramRsp),
        .gpioRsp  (gpioRsp),
        .busError (busError)
    );

    progMem prog (
        .clk  (clk),
        .rstn (rstn),
        .req  (progReq),
        .rsp  (progRsp),
        .fw   (fw)
    );

    dataRam ram (
        .clk  (clk),
        .rstn (rstn),
        .req  (ramReq),
        .rsp  (ramRsp)
    );

    gpioPort gpio (
        .clk     (clk),
        .rstn    (rstn),
        .req     (gpioReq),
        .rsp     (gpioRsp),
        .gpioOut (gpioOut)
    );

endmodule

`default_nettype wire

// File: tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release off the edge so nothing races the first active cycle
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rstn = 1'b1;
    end

endmodule

`default_nettype wire

// File: soc_checker.sv
`timescale 1ns/1ps
`default_nettype none

module socChecker (
    input wire                clk,
    input wire                rstn,
    input wire socPkg::busReq req,
    input wire socPkg::busRsp rsp,
    input wire                busError
);

    int failCount = 0;

    // ------------------------------------------------------------------------
    // Handshake
    // ------------------------------------------------------------------------

    readyNeedsValid: assert property (@(posedge clk) disable iff (!rstn)
        $rose(rsp.ready) |-> $past(req.valid))
    else begin
        $error("ready rose without valid in the previous cycle");
        failCount++;
    end

    // One-cycle acknowledge only
    readySinglePulse: assert property (@(posedge clk) disable iff (!rstn)
        rsp.ready |=> !rsp.ready)
    else begin
        $error("ready stayed high for two cycles in a row");
        failCount++;
    end

    rdataKnown: assert property (@(posedge clk) disable iff (!rstn)
        rsp.ready |-> !$isunknown(rsp.rdata))
    else begin
        $error("rdata has unknown bits while ready is high");
        failCount++;
    end

    // ------------------------------------------------------------------------
    // Error flag
    // ------------------------------------------------------------------------

    errorSticky: assert property (@(posedge clk) disable iff (!rstn)
        busError |=> busError)
    else begin
        $error("busError fell without a reset");
        failCount++;
    end

endmodule

`default_nettype wire

// File: socTb.sv
`include "soc_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module socTb;

    localparam int          CLK_PERIOD = 40;
    localparam int          TABLE_LEN  = 24;
    localparam int          WINDOW     = 16;
    localparam int          RANDOM_OPS = 40;
    localparam int          FW_WORDS   = 3;
    localparam int          OP_BUDGET  = TABLE_LEN + WINDOW + RANDOM_OPS + FW_WORDS;
    localparam logic [31:0] PROG_BASE  = `PROG_BASE;
    localparam logic [31:0] GPIO_ADDR  = `GPIO_ADDR;
    localparam logic [31:0] RAND_BASE  = 32'h0000_0200;
    localparam logic [31:0] RAM_BYTES  = 32'h1 << (`RAM_WORDS_LOG2 + 2);

    typedef enum logic [1:0] {FW_WRITE, BUS_WRITE, BUS_READ} opKind;

    // For FW_WRITE the addr field holds the word index
    typedef struct packed {
        opKind       kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] expData;
    } tableEntry;

    logic                   clk;
    logic                   rstn;
    socPkg::busReq          req;
    socPkg::busRsp          rsp;
    socPkg::fwWrite         fw;
    logic [`GPIO_WIDTH-1:0] gpioOut;
    logic                   busError;

    tableEntry              ops [0:TABLE_LEN-1];
    logic [31:0]            ramModel [0:(1 << `RAM_WORDS_LOG2)-1];
    logic [31:0]            progModel [int];
    logic [`GPIO_WIDTH-1:0] gpioModel;
    logic                   errModel;
    int                     valueErrors;
    int                     timeoutErrors;
    int                     wordIdx;
    socPkg::busRsp          got;
    logic [31:0]            curAddr;
    logic [31:0]            curData;
    logic [3:0]             curStrb;

    tbClock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(3)) clockGen (.clk(clk), .rstn(rstn));

    socTop uut (
        .clk      (clk),
        .rstn     (rstn),
        .req      (req),
        .rsp      (rsp),
        .fw       (fw),
        .gpioOut  (gpioOut),
        .busError (busError)
    );

    bind socTop socChecker busChecks (
        .clk      (clk),
        .rstn     (rstn),
        .req      (req),
        .rsp      (rsp),
        .busError (busError)
    );

    // ------------------------------------------------------------------------
    // Bus master and firmware port, called 2 ns after a rising edge
    // ------------------------------------------------------------------------

    task automatic busAccess(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] strb, output socPkg::busRsp rspOut);
        int waitCycles;
        waitCycles = 0;
        req = '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: strb};
        do begin
            @(posedge clk);
            #1;
            waitCycles++;
        end while (!rsp.ready && waitCycles < 4);
        rspOut = rsp;
        if (!rsp.ready) begin
            $display("No ready within 4 cycles for the access to address %h", addr);
            timeoutErrors++;
        end
        #1;
        req.valid = 1'b0;
        // Idle cycle so acknowledges from different targets never touch
        @(posedge clk);
        #2;
    endtask

    task automatic writeFirmware(input logic [`PROG_WORDS_LOG2-1:0] index,
                                 input logic [31:0] data);
        fw = '{wen: 1'b1, index: index, data: data};
        @(posedge clk);
        #2;
        fw.wen = 1'b0;
        progModel[int'(index)] = data;
    endtask

    // Reference model of the address map
    task automatic updateModel(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        if (addr[31:2] == GPIO_ADDR[31:2]) begin
            if (strb[0]) begin
                gpioModel = data[`GPIO_WIDTH-1:0];
            end
        end else if (addr[31:20] == 12'h001) begin
            // progMem ignores bus writes
        end else if (addr < RAM_BYTES) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    ramModel[addr[`RAM_WORDS_LOG2+1:2]][8*b +: 8] = data[8*b +: 8];
                end
            end
        end else begin
            errModel = 1'b1;
        end
    endtask

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------

    task automatic checkRsp(input logic [31:0] addr, input socPkg::busRsp gotRsp,
                            input logic [31:0] expData);
        if (gotRsp.rdata !== expData) begin
            $display("FAIL rsp.rdata at %h got %h expected %h", addr, gotRsp.rdata, expData);
            valueErrors++;
        end
    endtask

    task automatic checkGpio(input logic [`GPIO_WIDTH-1:0] gotOut,
                             input logic [`GPIO_WIDTH-1:0] expOut,
                             input logic gotErr, input logic expErr);
        if (gotOut !== expOut) begin
            $display("FAIL gpioOut got %h expected %h", gotOut, expOut);
            valueErrors++;
        end
        if (gotErr !== expErr) begin
            $display("FAIL busError got %h expected %h", gotErr, expErr);
            valueErrors++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    initial begin
        req           = '0;
        fw            = '0;
        gpioModel     = '0;
        errModel      = 1'b0;
        valueErrors   = 0;
        timeoutErrors = 0;
        void'($urandom(17));
        ops = '{
            '{FW_WRITE,  32'h0000_0000, 32'h0000_0013, 4'h0, 32'h0},
            '{FW_WRITE,  32'h0000_0001, 32'h1234_5678, 4'h0, 32'h0},
            '{FW_WRITE,  32'h0000_0002, 32'hCAFE_BABE, 4'h0, 32'h0},
            '{BUS_READ,  32'h0010_0000, 32'h0,         4'h0, 32'h0000_0013},
            '{BUS_READ,  32'h0010_0004, 32'h0,         4'h0, 32'h1234_5678},
            '{FW_WRITE,  32'h0000_0001, 32'hDEAD_BEEF, 4'h0, 32'h0},
            '{BUS_READ,  32'h0010_0004, 32'h0,         4'h0, 32'hDEAD_BEEF},
            '{BUS_READ,  32'h0010_0008, 32'h0,         4'h0, 32'hCAFE_BABE},
            '{BUS_WRITE, 32'h0010_0004, 32'h5555_5555, 4'hF, 32'h0},
            '{BUS_READ,  32'h0010_0004, 32'h0,         4'h0, 32'hDEAD_BEEF},
            '{BUS_WRITE, 32'h0000_0010, 32'h1122_3344, 4'hF, 32'h0},
            '{BUS_WRITE, 32'h0000_0010, 32'hAABB_CCDD, 4'h5, 32'h0},
            '{BUS_READ,  32'h0000_0010, 32'h0,         4'h0, 32'h11BB_33DD},
            '{BUS_WRITE, 32'h0000_0010, 32'h9988_7766, 4'h8, 32'h0},
            '{BUS_READ,  32'h0000_0010, 32'h0,         4'h0, 32'h99BB_33DD},
            '{BUS_WRITE, 32'h0000_0FFC, 32'h0BAD_F00D, 4'hF, 32'h0},
            '{BUS_READ,  32'h0000_0FFC, 32'h0,         4'h0, 32'h0BAD_F00D},
            '{BUS_READ,  GPIO_ADDR,     32'h0,         4'h0, 32'h0000_0000},
            '{BUS_WRITE, GPIO_ADDR,     32'h0000_00A5, 4'h1, 32'h0},
            '{BUS_READ,  GPIO_ADDR,     32'h0,         4'h0, 32'h0000_00A5},
            '{BUS_WRITE, GPIO_ADDR,     32'h0000_003C, 4'h2, 32'h0},
            '{BUS_READ,  GPIO_ADDR,     32'h0,         4'h0, 32'h0000_00A5},
            '{BUS_READ,  32'h0000_2000, 32'h0,         4'h0, 32'h0000_0000},
            '{BUS_READ,  32'h0000_0010, 32'h0,         4'h0, 32'h99BB_33DD}
        };

        wait (rstn === 1'b1);
        @(posedge clk);
        #2;
        checkGpio(gpioOut, gpioModel, busError, errModel);

        for (int i = 0; i < TABLE_LEN; i++) begin
            if (ops[i].kind == FW_WRITE) begin
                writeFirmware(ops[i].addr[`PROG_WORDS_LOG2-1:0], ops[i].data);
            end else begin
                busAccess(ops[i].addr, ops[i].data, ops[i].strb, got);
                updateModel(ops[i].addr, ops[i].data, ops[i].strb);
                // Writes return zero data
                checkRsp(ops[i].addr, got, (ops[i].kind == BUS_READ) ? ops[i].expData : 32'h0);
            end
            checkGpio(gpioOut, gpioModel, busError, errModel);
        end

        // Fill the random window first so every read hits known data
        for (int w = 0; w < WINDOW; w++) begin
            curAddr = RAND_BASE + 32'(4 * w);
            curData = (curAddr * 32'h9E37_79B9) ^ 32'h5A5A_0F0F;
            busAccess(curAddr, curData, 4'hF, got);
            checkRsp(curAddr, got, 32'h0);
            updateModel(curAddr, curData, 4'hF);
        end

        for (int n = 0; n < RANDOM_OPS; n++) begin
            wordIdx = $urandom_range(WINDOW - 1, 0);
            curAddr = RAND_BASE + 32'(4 * wordIdx);
            curData = $urandom;
            curStrb = ($urandom_range(1, 0) == 1) ? 4'($urandom_range(15, 1)) : 4'h0;
            busAccess(curAddr, curData, curStrb, got);
            if (curStrb == 4'h0) begin
                checkRsp(curAddr, got, ramModel[curAddr[`RAM_WORDS_LOG2+1:2]]);
            end else begin
                checkRsp(curAddr, got, 32'h0);
            end
            updateModel(curAddr, curData, curStrb);
        end

        // Firmware words survive everything above
        foreach (progModel[i]) begin
            curAddr = PROG_BASE + 32'(4 * i);
            busAccess(curAddr, 32'h0, 4'h0, got);
            checkRsp(curAddr, got, progModel[i]);
        end
        checkGpio(gpioOut, gpioModel, busError, errModel);

        $display("Errors: %0d value mismatches, %0d missing ready, %0d assertion failures",
                 valueErrors, timeoutErrors, uut.busChecks.failCount);
        if (valueErrors + timeoutErrors + uut.busChecks.failCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // ------------------------------------------------------------------------
    // Watchdog
    // ------------------------------------------------------------------------

    initial begin
        #((OP_BUDGET * 4 + 100) * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
socPkg.sv
progMem.sv
dataRam.sv
gpioPort.sv
busDecode.sv
socTop.sv
tbClock.sv
soc_checker.sv
socTb.sv

// File: Bender.yml
package:
  name: soc_mem

sources:
  - include_dirs:
      - .
    files:
      - socPkg.sv
      - progMem.sv
      - dataRam.sv
      - gpioPort.sv
      - busDecode.sv
      - socTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbClock.sv
      - soc_checker.sv
      - socTb.sv
